//--- tb.f
+incdir+.
lane_isa_pkg.sv
lane_stream_pkg.sv
stream_fifo.sv
lane_decoder.sv
addr_sequencer.sv
vector_exec.sv
vector_lane.sv
tb_vector_lane.sv

//--- run.sh
#!/bin/sh
# build and run the vector lane testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_vector_lane -f tb.f > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_vector_lane > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation finished cleanly"

//--- tb_vector_lane.sv
`include "lane_config.svh"
`default_nettype none

module tb_vector_lane;
    timeunit 1ns;
    timeprecision 1ps;

    import lane_isa_pkg::*;

    localparam int WORD_W = `LANE_COUNT * `LANE_WIDTH;

    logic                    clk;
    logic                    i_rst_n;
    logic [`INSTR_WIDTH-1:0] i_instr;
    logic                    i_instr_valid;
    logic                    o_busy;
    logic                    o_done;
    logic [WORD_W-1:0]       i_tdata_in;
    logic                    i_tvalid_in;
    logic                    o_tready_in;
    logic [WORD_W-1:0]       o_tdata_out;
    logic                    o_tvalid_out;
    logic                    i_tready_out;

    logic [WORD_W-1:0] vrf_model [`VRF_DEPTH];  // expected register contents
    logic [WORD_W-1:0] in_q[$];                 // words still to be offered
    logic [WORD_W-1:0] exp_q[$];                // words expected on the output
    logic [15:0]       lfsr_q;
    logic              gap_en;                  // random input gaps
    logic              bp_en;                   // random output back-pressure
    logic              prev_held;
    logic [WORD_W-1:0] prev_data;

    vector_lane u_dut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_instr      (i_instr),
        .i_instr_valid(i_instr_valid),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .i_tdata_in   (i_tdata_in),
        .i_tvalid_in  (i_tvalid_in),
        .o_tready_in  (o_tready_in),
        .o_tdata_out  (o_tdata_out),
        .o_tvalid_out (o_tvalid_out),
        .i_tready_out (i_tready_out)
    );

    always #10 clk = ~clk;

    // galois lfsr stepped once per random bit
    function automatic logic lfsr_step();
        logic lsb;
        lsb = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [WORD_W-1:0] rand_word();
        logic [WORD_W-1:0] w;
        for (int l = 0; l < `LANE_COUNT; l++) begin
            w[l*`LANE_WIDTH +: `LANE_WIDTH] = 16'(rand_bits(16));
        end
        return w;
    endfunction

    // acc + in * rd per lane truncated to the lane width
    function automatic logic [WORD_W-1:0] mac_model(input logic [WORD_W-1:0] acc,
                                                    input logic [WORD_W-1:0] in_w,
                                                    input logic [WORD_W-1:0] rd_w);
        logic [WORD_W-1:0] res;
        logic [31:0]       prod;
        for (int l = 0; l < `LANE_COUNT; l++) begin
            prod = in_w[l*`LANE_WIDTH +: `LANE_WIDTH] * rd_w[l*`LANE_WIDTH +: `LANE_WIDTH];
            res[l*`LANE_WIDTH +: `LANE_WIDTH] = acc[l*`LANE_WIDTH +: `LANE_WIDTH] + prod[15:0];
        end
        return res;
    endfunction

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // one clock of stream traffic driven on the falling edge
    task automatic cycle();
        @(negedge clk);
        if (prev_held) begin
            check_value("o_tvalid_out", 64'(o_tvalid_out), 64'd1);
            check_value("o_tdata_out", o_tdata_out, prev_data);  // stalled head
        end
        if (in_q.size() > 0 && (!gap_en || lfsr_step())) begin
            i_tvalid_in = 1'b1;
            i_tdata_in  = in_q[0];
            if (o_tready_in) begin
                void'(in_q.pop_front());  // taken on the next rising edge
            end
        end else begin
            i_tvalid_in = 1'b0;
        end
        i_tready_out = bp_en ? (rand_bits(3) == 0) : 1'b1;
        if (o_tvalid_out && i_tready_out) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output word %h at %0t", o_tdata_out, $time);
                stop_on_error();
            end
            check_value("o_tdata_out", o_tdata_out, exp_q.pop_front());
        end
        prev_held = o_tvalid_out && !i_tready_out;
        prev_data = o_tdata_out;
    endtask

    // model side of one instruction, queues its stream words
    task automatic apply_model(input opcode_e op, input logic [3:0] vr, input logic [3:0] vw,
                               input logic [3:0] len);
        logic [WORD_W-1:0] word;
        logic [WORD_W-1:0] rd_w;
        logic [3:0]        ra;
        logic [3:0]        wa;
        for (int k = 0; k <= int'(len); k++) begin
            ra = vr + 4'(k);  // wraps at 16
            wa = vw + 4'(k);
            case (op)
                OP_VCLR: begin
                    vrf_model[wa] = '0;
                end
                OP_VLOAD: begin
                    word = rand_word();
                    in_q.push_back(word);
                    vrf_model[wa] = word;
                end
                OP_VMACC: begin
                    word = rand_word();
                    in_q.push_back(word);
                    rd_w = vrf_model[ra];
                    vrf_model[wa] = mac_model(vrf_model[wa], word, rd_w);
                end
                default: begin
                    exp_q.push_back(vrf_model[ra]);
                end
            endcase
        end
    endtask

    // strobe the instruction into the idle lane
    task automatic send_instr(input opcode_e op, input logic [3:0] vr, input logic [3:0] vw,
                              input logic [3:0] len);
        cycle();
        i_instr       = {4'(op), vr, vw, len};
        i_instr_valid = 1'b1;
        cycle();
        i_instr_valid = 1'b0;
        check_value("o_busy", 64'(o_busy), 64'd1);
    endtask

    task automatic issue(input opcode_e op, input logic [3:0] vr, input logic [3:0] vw,
                         input logic [3:0] len);
        apply_model(op, vr, vw, len);
        send_instr(op, vr, vw, len);
    endtask

    // offer queued words with no run active until the input fifo refuses more
    task automatic fill_input(input int limit);
        int n;
        int taken;
        n = 0;
        taken = in_q.size();
        while (o_tready_in) begin
            if (n == limit) begin
                $display("timeout: o_tready_in never dropped while the input fifo filled");
                stop_on_error();
            end
            cycle();
            n++;
        end
        taken = taken - in_q.size();
        check_value("input words taken", 64'(taken), 64'(`FIFO_DEPTH));
    endtask

    task automatic wait_done(input int limit, output int busy_cycles);
        int n;
        n = 0;
        busy_cycles = 0;
        while (!o_done) begin
            if (o_busy) begin
                busy_cycles++;
            end
            if (n == limit) begin
                $display("timeout: no o_done pulse within %0d cycles", limit);
                stop_on_error();
            end
            cycle();
            n++;
        end
        check_value("o_busy", 64'(o_busy), 64'd0);
        cycle();
        check_value("o_done", 64'(o_done), 64'd0);  // single-cycle pulse
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0) begin
            if (n == limit) begin
                $display("timeout: %0d output words never arrived", exp_q.size());
                stop_on_error();
            end
            cycle();
            n++;
        end
        cycle();
        check_value("o_tvalid_out", 64'(o_tvalid_out), 64'd0);
    endtask

    initial begin
        int         bc;
        logic [3:0] vr;
        logic [3:0] vw;
        logic [3:0] len;
        logic [3:0] op_raw;
        clk           = 1'b0;
        i_rst_n       = 1'b0;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        i_tdata_in    = '0;
        i_tvalid_in   = 1'b0;
        i_tready_out  = 1'b1;
        lfsr_q        = 16'd7;
        gap_en        = 1'b0;
        bp_en         = 1'b0;
        prev_held     = 1'b0;
        prev_data     = '0;
        repeat (10) @(negedge clk);
        i_rst_n = 1'b1;

        check_value("o_busy", 64'(o_busy), 64'd0);
        check_value("o_done", 64'(o_done), 64'd0);
        check_value("o_tvalid_out", 64'(o_tvalid_out), 64'd0);
        check_value("o_tready_in", 64'(o_tready_in), 64'd1);

        // clear a range and read it back
        vw  = 4'(rand_bits(4));
        len = 4'(rand_bits(4));
        issue(OP_VCLR, 4'd0, vw, len);
        wait_done(100, bc);
        check_value("vclr busy cycles", 64'(bc), 64'(len) + 64'd1);
        issue(OP_VSTREAMOUT, vw, 4'd0, len);
        wait_done(200, bc);
        wait_drain(200);

        gap_en = 1'b1;
        vw  = 4'd12 + 4'(rand_bits(2));  // range runs past entry 15
        len = 4'd7 + 4'(rand_bits(3));
        issue(OP_VLOAD, 4'd0, vw, len);
        wait_done(400, bc);
        issue(OP_VSTREAMOUT, vw, 4'd0, len);
        wait_done(200, bc);
        wait_drain(200);

        // fill every entry before random vmacc ranges
        issue(OP_VLOAD, 4'd0, 4'd0, 4'd15);
        wait_done(600, bc);
        for (int t = 0; t < 6; t++) begin
            vr  = 4'(rand_bits(4));
            vw  = (t % 2 == 0) ? vr + 4'(rand_bits(2)) : 4'(rand_bits(4));  // overlap
            len = 4'(rand_bits(4));
            issue(OP_VMACC, vr, vw, len);
            wait_done(600, bc);
            issue(OP_VSTREAMOUT, vw, 4'd0, len);
            wait_done(200, bc);
            wait_drain(200);
        end

        // input fifo filled ahead of the load so o_tready_in drops
        vr = 4'(rand_bits(4));
        apply_model(OP_VLOAD, 4'd0, vr, 4'd15);
        fill_input(100);
        send_instr(OP_VLOAD, 4'd0, vr, 4'd15);
        wait_done(600, bc);

        // output back-pressure on a full-length stream out
        bp_en = 1'b1;
        issue(OP_VSTREAMOUT, vr, 4'd0, 4'd15);
        wait_done(1000, bc);
        if (bc <= 16) begin
            $display("vstreamout never stalled under back-pressure");
            stop_on_error();
        end
        wait_drain(1000);
        bp_en = 1'b0;

        // a vclr strobed while busy must be dropped
        vw  = 4'(rand_bits(4));
        len = 4'd4 + 4'(rand_bits(3));
        issue(OP_VLOAD, 4'd0, vw, len);
        i_instr       = {4'(OP_VCLR), 4'd0, vw, len};
        i_instr_valid = 1'b1;
        cycle();
        i_instr_valid = 1'b0;
        wait_done(400, bc);
        issue(OP_VSTREAMOUT, vw, 4'd0, len);
        wait_done(200, bc);
        wait_drain(200);

        gap_en = 1'b0;
        op_raw = 4'(rand_bits(4));
        if (op_raw inside {4'd1, 4'd2, 4'd3, 4'd4}) begin
            op_raw = op_raw + 4'd4;
        end
        i_instr       = {op_raw, 12'(rand_bits(12))};
        i_instr_valid = 1'b1;
        cycle();
        i_instr_valid = 1'b0;
        for (int c = 0; c < 50; c++) begin
            check_value("o_busy", 64'(o_busy), 64'd0);
            check_value("o_done", 64'(o_done), 64'd0);
            cycle();
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vector_lane.sv
`include "lane_config.svh"
`default_nettype none

module vector_lane (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic [`INSTR_WIDTH-1:0]       i_instr,
    input  wire logic                          i_instr_valid,
    output logic                               o_busy,
    output logic                               o_done,
    input  wire lane_stream_pkg::stream_word_t i_tdata_in,
    input  wire logic                          i_tvalid_in,
    output logic                               o_tready_in,
    output lane_stream_pkg::stream_word_t      o_tdata_out,
    output logic                               o_tvalid_out,
    input  wire logic                          i_tready_out
);
    import lane_isa_pkg::*;
    import lane_stream_pkg::*;

    // decoder to sequencer
    logic         dec_start;
    opcode_e      dec_op;
    vaddr_t       dec_vr;
    vaddr_t       dec_vw;
    len_t         dec_len;

    // sequencer to execute and fifos
    opcode_e      seq_op;
    vaddr_t       rd_addr;
    vaddr_t       wr_addr;
    logic         wen;
    logic         pop_in;
    logic         push_out;

    stream_word_t in_word;
    stream_word_t rd_word;
    logic         in_empty;
    logic         in_full;
    logic         out_empty;
    logic         out_full;

    assign o_tready_in  = !in_full;
    assign o_tvalid_out = !out_empty;

    stream_fifo u_fifo_in (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_tvalid_in),   // ignored when full
        .i_pop   (pop_in),
        .i_din   (i_tdata_in),
        .o_dout  (in_word),
        .o_empty (in_empty),
        .o_full  (in_full)
    );

    lane_decoder u_decoder (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .i_busy        (o_busy),
        .o_start       (dec_start),
        .o_op          (dec_op),
        .o_vr          (dec_vr),
        .o_vw          (dec_vw),
        .o_len         (dec_len)
    );

    addr_sequencer u_sequencer (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_start    (dec_start),
        .i_op       (dec_op),
        .i_vr       (dec_vr),
        .i_vw       (dec_vw),
        .i_len      (dec_len),
        .i_in_empty (in_empty),
        .i_out_full (out_full),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_op       (seq_op),
        .o_rd_addr  (rd_addr),
        .o_wr_addr  (wr_addr),
        .o_wen      (wen),
        .o_pop_in   (pop_in),
        .o_push_out (push_out)
    );

    vector_exec u_exec (
        .clk       (clk),
        .i_op      (seq_op),
        .i_rd_addr (rd_addr),
        .i_wr_addr (wr_addr),
        .i_wen     (wen),
        .i_in_word (in_word),
        .o_rd_word (rd_word)
    );

    stream_fifo u_fifo_out (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_push  (push_out),
        .i_pop   (i_tready_out),  // ignored when empty
        .i_din   (rd_word),
        .o_dout  (o_tdata_out),
        .o_empty (out_empty),
        .o_full  (out_full)
    );

endmodule

`default_nettype wire

//--- vector_exec.sv
`include "lane_config.svh"
`default_nettype none

module vector_exec (
    input  wire logic                          clk,
    input  wire lane_isa_pkg::opcode_e         i_op,
    input  wire lane_isa_pkg::vaddr_t          i_rd_addr,
    input  wire lane_isa_pkg::vaddr_t          i_wr_addr,
    input  wire logic                          i_wen,
    input  wire lane_stream_pkg::stream_word_t i_in_word,
    output lane_stream_pkg::stream_word_t      o_rd_word
);
    import lane_isa_pkg::*;
    import lane_stream_pkg::*;

    stream_word_t vrf [`VRF_DEPTH];
    stream_word_t old_word;   // accumulator operand at the write address
    stream_word_t wr_word;

    // both read ports are combinational, so a step sees all earlier writes
    assign o_rd_word = vrf[i_rd_addr];
    assign old_word  = vrf[i_wr_addr];

    always_comb begin
        case (i_op)
            OP_VCLR: begin
                wr_word = '0;
            end
            OP_VLOAD: begin
                wr_word = i_in_word;  // stream head popped in the same step
            end
            OP_VMACC: begin
                for (int l = 0; l < `LANE_COUNT; l++) begin
                    wr_word[l] = mac_lane(old_word[l], i_in_word[l], o_rd_word[l]);
                end
            end
            default: begin
                wr_word = '0;  // vstreamout only reads
            end
        endcase
    end

    // one entry written per step
    always_ff @(posedge clk) begin
        if (i_wen) begin
            vrf[i_wr_addr] <= wr_word;
        end
    end

endmodule

`default_nettype wire

//--- addr_sequencer.sv
`include "lane_config.svh"
`default_nettype none

module addr_sequencer (
    input  wire logic                  clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_start,
    input  wire lane_isa_pkg::opcode_e i_op,
    input  wire lane_isa_pkg::vaddr_t  i_vr,
    input  wire lane_isa_pkg::vaddr_t  i_vw,
    input  wire lane_isa_pkg::len_t    i_len,
    input  wire logic                  i_in_empty,
    input  wire logic                  i_out_full,
    output logic                       o_busy,
    output logic                       o_done,
    output lane_isa_pkg::opcode_e      o_op,
    output lane_isa_pkg::vaddr_t       o_rd_addr,
    output lane_isa_pkg::vaddr_t       o_wr_addr,
    output logic                       o_wen,
    output logic                       o_pop_in,
    output logic                       o_push_out
);
    import lane_isa_pkg::*;

    seq_state_e state_q;
    opcode_e    op_q;
    vaddr_t     rd_ptr_q;
    vaddr_t     wr_ptr_q;
    len_t       left_q;    // remaining elements minus one
    logic       done_q;

    opcode_e    cur_op;
    vaddr_t     cur_rd;
    vaddr_t     cur_wr;
    len_t       cur_left;
    logic       active;
    logic       stall;
    logic       step;
    logic       last;

    // the start cycle already runs step 0 from the decoder fields
    assign active   = i_start || (state_q == SEQ_RUN);
    assign cur_op   = i_start ? i_op  : op_q;
    assign cur_rd   = i_start ? i_vr  : rd_ptr_q;
    assign cur_wr   = i_start ? i_vw  : wr_ptr_q;
    assign cur_left = i_start ? i_len : left_q;

    always_comb begin
        case (cur_op)
            OP_VLOAD, OP_VMACC: stall = i_in_empty;  // wait for a stream word
            OP_VSTREAMOUT:      stall = i_out_full;  // wait for output room
            default:            stall = 1'b0;        // vclr never waits
        endcase
    end

    assign step = active && !stall;
    assign last = step && (cur_left == '0);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q  <= SEQ_IDLE;
            op_q     <= OP_VCLR;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            left_q   <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last;
            if (last) begin
                state_q <= SEQ_IDLE;
            end else if (active) begin
                state_q <= SEQ_RUN;
                op_q    <= cur_op;
                if (step) begin
                    rd_ptr_q <= cur_rd + 1'b1;  // wraps at 16
                    wr_ptr_q <= cur_wr + 1'b1;
                    left_q   <= cur_left - 1'b1;
                end else begin
                    rd_ptr_q <= cur_rd;         // hold on stall
                    wr_ptr_q <= cur_wr;
                    left_q   <= cur_left;
                end
            end
        end
    end

    assign o_busy     = active;
    assign o_done     = done_q;
    assign o_op       = cur_op;
    assign o_rd_addr  = cur_rd;   // vmacc multiplicand and vstreamout source
    assign o_wr_addr  = cur_wr;
    assign o_wen      = step && (cur_op inside {OP_VCLR, OP_VLOAD, OP_VMACC});
    assign o_pop_in   = step && (cur_op inside {OP_VLOAD, OP_VMACC});
    assign o_push_out = step && (cur_op == OP_VSTREAMOUT);

    a_no_start_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_start |-> (state_q == SEQ_IDLE) && !done_q);

    a_done_after_run: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_done |-> !o_busy && $past(active));

endmodule

`default_nettype wire

//--- lane_decoder.sv
`include "lane_config.svh"
`default_nettype none

module lane_decoder (
    input  wire logic                    clk,
    input  wire logic                    i_rst_n,
    input  wire logic [`INSTR_WIDTH-1:0] i_instr,
    input  wire logic                    i_instr_valid,
    input  wire logic                    i_busy,
    output logic                         o_start,
    output lane_isa_pkg::opcode_e        o_op,
    output lane_isa_pkg::vaddr_t         o_vr,
    output lane_isa_pkg::vaddr_t         o_vw,
    output lane_isa_pkg::len_t           o_len
);
    import lane_isa_pkg::*;

    instr_t  instr;
    opcode_e op_dec;
    logic    known;
    logic    accept;

    assign instr = instr_t'(i_instr);

    always_comb begin
        case (instr.opcode)
            OP_VCLR, OP_VLOAD, OP_VMACC, OP_VSTREAMOUT: begin
                known  = 1'b1;
                op_dec = opcode_e'(instr.opcode);
            end
            default: begin
                known  = 1'b0;
                op_dec = OP_VCLR;  // unused while known is low
            end
        endcase
    end

    // strobes while busy or with unknown opcodes fall on the floor
    assign accept = i_instr_valid && !i_busy && known;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_start <= 1'b0;
        end else begin
            o_start <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_op  <= op_dec;
            o_vr  <= instr.vr;
            o_vw  <= instr.vw;
            o_len <= instr.len;
        end
    end

    // start only for isa codes 1 to 4, carrying the strobed opcode
    a_start_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_start |-> ($past(i_instr[15:12]) inside {4'd1, 4'd2, 4'd3, 4'd4})
                    && (o_op == $past(i_instr[15:12])));

    // sequencer raises busy during the start cycle, so no back-to-back start
    a_start_single: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_start |=> !o_start);

endmodule

`default_nettype wire

//--- stream_fifo.sv
`include "lane_config.svh"
`default_nettype none

module stream_fifo (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_push,
    input  wire logic                          i_pop,
    input  wire lane_stream_pkg::stream_word_t i_din,
    output lane_stream_pkg::stream_word_t      o_dout,
    output logic                               o_empty,
    output logic                               o_full
);
    import lane_stream_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = `FIFO_DEPTH;

    stream_word_t     mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == FULL_COUNT);
    assign do_push = i_push && !o_full;   // push on full is dropped
    assign do_pop  = i_pop && !o_empty;   // pop on empty is dropped
    assign o_dout  = mem[rd_ptr_q];       // head falls through

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // occupancy stays within the buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        count_q <= FULL_COUNT);

    // an empty fifo can only stay empty or gain one word
    a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        (count_q == '0) |=> (count_q <= 1));

endmodule

`default_nettype wire

//--- lane_stream_pkg.sv
`include "lane_config.svh"
`default_nettype none

package lane_stream_pkg;

    // one lane value
    typedef logic [`LANE_WIDTH-1:0] lane_word_t;

    // lane 0 sits in the low bits
    typedef lane_word_t [`LANE_COUNT-1:0] stream_word_t;

    // truncating multiply-accumulate of one lane
    function automatic lane_word_t mac_lane(
        input lane_word_t acc,
        input lane_word_t a,
        input lane_word_t b
    );
        return acc + a * b;
    endfunction

endpackage

`default_nettype wire

//--- lane_isa_pkg.sv
`include "lane_config.svh"
`default_nettype none

package lane_isa_pkg;

    // opcode in instr[15:12] and any other code is unknown
    typedef enum logic [3:0] {
        OP_VCLR       = 4'd1,  // zero fill, vmv.v.i path
        OP_VLOAD      = 4'd2,  // stream words into entries
        OP_VMACC      = 4'd3,  // lane-wise multiply-accumulate
        OP_VSTREAMOUT = 4'd4   // entries to output stream
    } opcode_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    typedef logic [`VRF_ADDR_W-1:0] vaddr_t;

    // run length minus one
    typedef logic [3:0] len_t;

    typedef struct packed {
        logic [3:0] opcode;  // bits 15..12
        vaddr_t     vr;      // bits 11..8
        vaddr_t     vw;      // bits 7..4
        len_t       len;     // bits 3..0
    } instr_t;

endpackage

`default_nettype wire

//--- lane_config.svh
`ifndef LANE_CONFIG_SVH
`define LANE_CONFIG_SVH

// number of simd lanes per stream word
`define LANE_COUNT 4

// bits per lane
`define LANE_WIDTH 16

// vector register file entries and address width
`define VRF_DEPTH 16
`define VRF_ADDR_W 4

// words per stream fifo
`define FIFO_DEPTH 8

// instruction word width
`define INSTR_WIDTH 16

`endif
